//--- hw/gpio_pkg.sv
// GPIO shared definitions
// Register map, interrupt type encoding, reset defaults and data word views
package gpio_pkg;

    localparam int DATA_W    = 32;
    localparam int REG_IDX_W = 5;

    // Word index taken from PADDR[6:2]
    typedef enum logic [REG_IDX_W-1:0] {
        REG_PADDIR     = 5'd0,
        REG_GPIOEN     = 5'd1,
        REG_PADIN      = 5'd2,
        REG_PADOUT     = 5'd3,
        REG_PADOUTSET  = 5'd4,
        REG_PADOUTCLR  = 5'd5,
        REG_INTEN      = 5'd6,
        REG_INTTYPE_LO = 5'd7,  // pads 0-15
        REG_INTTYPE_HI = 5'd8,  // pads 16-31
        REG_INTSTATUS  = 5'd9
    } gpio_reg_e;

    typedef enum logic [1:0] {
        INT_FALL = 2'b00,
        INT_RISE = 2'b01,
        INT_BOTH = 2'b10,
        INT_NONE = 2'b11
    } int_type_e;

    // Pads 0-9 come out of reset as outputs
    localparam logic [DATA_W-1:0] DIR_RESET = 32'h0000_03FF;

    // One APB word, flat or as 16 interrupt type fields
    typedef union packed {
        logic [DATA_W-1:0]        flat;
        int_type_e [DATA_W/2-1:0] types;
    } gpio_word_u;

endpackage

//--- hw/gpio_cfg_if.sv
`timescale 1ns/1ps
// GPIO configuration and status bundle
// Joins the register block, input synchroniser and interrupt controller
interface gpio_cfg_if import gpio_pkg::*; #(
    parameter int NUM_PADS = 32
) ();

    logic [NUM_PADS-1:0]     pad_en;
    logic [NUM_PADS-1:0]     int_en;
    int_type_e [NUM_PADS-1:0] int_type;
    logic                    status_rd;  // INTSTATUS read strobe
    logic [NUM_PADS-1:0]     pad_in;
    logic [NUM_PADS-1:0]     rise;
    logic [NUM_PADS-1:0]     fall;
    logic [NUM_PADS-1:0]     status;

    modport regs (
        output pad_en, int_en, int_type, status_rd,
        input  pad_in, status
    );

    modport sync (
        input  pad_en,
        output pad_in, rise, fall
    );

    modport irq (
        input  pad_en, int_en, int_type, status_rd, rise, fall,
        output status
    );

endinterface

//--- hw/gpio_apb_regs.sv
`timescale 1ns/1ps
// GPIO APB register block
// Decodes APB accesses, holds the pad control registers, builds read data
module gpio_apb_regs import gpio_pkg::*; #(
    parameter int NUM_PADS   = 32,
    parameter int APB_ADDR_W = 12
) (
    input  logic                  HCLK,
    input  logic                  HRESETn,
    input  logic [APB_ADDR_W-1:0] PADDR,
    input  logic [DATA_W-1:0]     PWDATA,
    input  logic                  PWRITE,
    input  logic                  PSEL,
    input  logic                  PENABLE,
    output logic [DATA_W-1:0]     PRDATA,
    gpio_cfg_if.regs              cfg,
    output logic [NUM_PADS-1:0]   gpio_out,
    output logic [NUM_PADS-1:0]   gpio_dir
);

    gpio_reg_e                reg_idx;
    logic                     wr_en;
    logic                     rd_en;
    logic [NUM_PADS-1:0]      wdata;
    gpio_word_u               wr_word;
    gpio_word_u               rd_word;

    logic [NUM_PADS-1:0]      dir_q;
    logic [NUM_PADS-1:0]      out_q;
    logic [NUM_PADS-1:0]      en_q;
    logic [NUM_PADS-1:0]      inten_q;
    int_type_e [NUM_PADS-1:0] itype_q;

    // Upper address bits are not decoded, the 128 byte map aliases
    assign reg_idx = gpio_reg_e'(PADDR[REG_IDX_W+1:2]);

    assign wr_en = PSEL & PENABLE & PWRITE;
    assign rd_en = PSEL & PENABLE & ~PWRITE;

    assign wdata        = PWDATA[NUM_PADS-1:0];  // bits above NUM_PADS dropped
    assign wr_word.flat = PWDATA;

    always_ff @(posedge HCLK or negedge HRESETn)
    begin
        if (!HRESETn)
        begin
            dir_q   <= DIR_RESET[NUM_PADS-1:0];
            out_q   <= '0;
            en_q    <= '0;
            inten_q <= '0;
            for (int i = 0; i < NUM_PADS; i++)
                itype_q[i] <= INT_FALL;
        end
        else if (wr_en)
        begin
            case (reg_idx)
                REG_PADDIR:    dir_q   <= wdata;
                REG_GPIOEN:    en_q    <= wdata;
                REG_PADOUT:    out_q   <= wdata;
                REG_PADOUTSET: out_q   <= out_q | wdata;
                REG_PADOUTCLR: out_q   <= out_q & ~wdata;
                REG_INTEN:     inten_q <= wdata;
                REG_INTTYPE_LO, REG_INTTYPE_HI:
                begin
                    // Each word carries 16 pads, low or high half
                    for (int i = 0; i < NUM_PADS; i++)
                    begin
                        if ((i >= 16) == (reg_idx == REG_INTTYPE_HI))
                            itype_q[i] <= wr_word.types[i % 16];
                    end
                end
                default:
                begin
                    // PADIN, INTSTATUS and unmapped words are read only
                end
            endcase
        end
    end

    // Read data is zero outside a read access phase
    always_comb
    begin
        rd_word.flat = '0;
        if (rd_en)
        begin
            case (reg_idx)
                REG_PADDIR:    rd_word.flat = DATA_W'(dir_q);
                REG_GPIOEN:    rd_word.flat = DATA_W'(en_q);
                REG_PADIN:     rd_word.flat = DATA_W'(cfg.pad_in);
                REG_PADOUT:    rd_word.flat = DATA_W'(out_q);
                REG_INTEN:     rd_word.flat = DATA_W'(inten_q);
                REG_INTTYPE_LO, REG_INTTYPE_HI:
                begin
                    for (int i = 0; i < NUM_PADS; i++)
                    begin
                        if ((i >= 16) == (reg_idx == REG_INTTYPE_HI))
                            rd_word.types[i % 16] = itype_q[i];
                    end
                end
                REG_INTSTATUS: rd_word.flat = DATA_W'(cfg.status);
                default:       rd_word.flat = '0;  // set/clr aliases too
            endcase
        end
    end

    assign PRDATA = rd_word.flat;

    // Status clears at the end of this access
    assign cfg.status_rd = rd_en & (reg_idx == REG_INTSTATUS);

    assign cfg.pad_en   = en_q;
    assign cfg.int_en   = inten_q;
    assign cfg.int_type = itype_q;

    assign gpio_out = out_q;
    assign gpio_dir = dir_q;

endmodule

//--- hw/gpio_in_sync.sv
`timescale 1ns/1ps
// GPIO input synchroniser
// Three-stage chain per pad, clocked per group of four enabled pads
module gpio_in_sync #(
    parameter int NUM_PADS = 32
) (
    input  logic                HCLK,
    input  logic                HRESETn,
    input  logic [NUM_PADS-1:0] gpio_in,
    gpio_cfg_if.sync            cfg
);

    localparam int NUM_GRP = NUM_PADS / 4;

    logic [NUM_GRP-1:0]  grp_en;
    logic [NUM_PADS-1:0] sync0;
    logic [NUM_PADS-1:0] sync1;
    logic [NUM_PADS-1:0] sync2;

    // A group runs when any of its four pads is enabled
    always_comb
    begin
        for (int g = 0; g < NUM_GRP; g++)
            grp_en[g] = |cfg.pad_en[4*g +: 4];
    end

    always_ff @(posedge HCLK or negedge HRESETn)
    begin
        if (!HRESETn)
        begin
            sync0 <= '0;
            sync1 <= '0;
            sync2 <= '0;
        end
        else
        begin
            for (int i = 0; i < NUM_PADS; i++)
            begin
                if (grp_en[i/4])
                begin
                    sync0[i] <= gpio_in[i];
                    sync1[i] <= sync0[i];
                    sync2[i] <= sync1[i];
                end
            end
        end
    end

    assign cfg.pad_in = sync2;
    assign cfg.rise   = sync1 & ~sync2;  // new value not yet in last stage
    assign cfg.fall   = ~sync1 & sync2;

endmodule

//--- hw/gpio_irq_ctrl.sv
`timescale 1ns/1ps
// GPIO interrupt controller
// Qualifies pad edges by type and enables, keeps the sticky status
module gpio_irq_ctrl import gpio_pkg::*; #(
    parameter int NUM_PADS = 32
) (
    input  logic     HCLK,
    input  logic     HRESETn,
    gpio_cfg_if.irq  cfg,
    output logic     interrupt
);

    logic [NUM_PADS-1:0] type_hit;
    logic [NUM_PADS-1:0] irq_evt;
    logic [NUM_PADS-1:0] status;

    always_comb
    begin
        for (int i = 0; i < NUM_PADS; i++)
        begin
            case (cfg.int_type[i])
                INT_FALL: type_hit[i] = cfg.fall[i];
                INT_RISE: type_hit[i] = cfg.rise[i];
                INT_BOTH: type_hit[i] = cfg.rise[i] | cfg.fall[i];
                default:  type_hit[i] = 1'b0;  // INT_NONE
            endcase
        end
    end

    assign irq_evt   = type_hit & cfg.int_en & cfg.pad_en;
    assign interrupt = |irq_evt;

    // A new event wins over the read clear
    always_ff @(posedge HCLK or negedge HRESETn)
    begin
        if (!HRESETn)
            status <= '0;
        else if (interrupt)
            status <= status | irq_evt;
        else if (cfg.status_rd)
            status <= '0;
    end

    assign cfg.status = status;

endmodule

//--- hw/gpio_top.sv
`timescale 1ns/1ps
// APB GPIO top level
// Register block and input synchroniser feeding the interrupt controller
module gpio_top import gpio_pkg::*; #(
    parameter int NUM_PADS   = 32,
    parameter int APB_ADDR_W = 12
) (
    input  logic                  HCLK,
    input  logic                  HRESETn,

    input  logic [APB_ADDR_W-1:0] PADDR,
    input  logic [DATA_W-1:0]     PWDATA,
    input  logic                  PWRITE,
    input  logic                  PSEL,
    input  logic                  PENABLE,
    output logic [DATA_W-1:0]     PRDATA,
    output logic                  PREADY,
    output logic                  PSLVERR,

    input  logic [NUM_PADS-1:0]   gpio_in,
    output logic [NUM_PADS-1:0]   gpio_out,
    output logic [NUM_PADS-1:0]   gpio_dir,
    output logic                  interrupt
);

    gpio_cfg_if #(.NUM_PADS(NUM_PADS)) cfg ();

    gpio_apb_regs #(
        .NUM_PADS   (NUM_PADS),
        .APB_ADDR_W (APB_ADDR_W)
    ) u_regs (
        .HCLK     (HCLK),
        .HRESETn  (HRESETn),
        .PADDR    (PADDR),
        .PWDATA   (PWDATA),
        .PWRITE   (PWRITE),
        .PSEL     (PSEL),
        .PENABLE  (PENABLE),
        .PRDATA   (PRDATA),
        .cfg      (cfg.regs),
        .gpio_out (gpio_out),
        .gpio_dir (gpio_dir)
    );

    gpio_in_sync #(
        .NUM_PADS (NUM_PADS)
    ) u_sync (
        .HCLK    (HCLK),
        .HRESETn (HRESETn),
        .gpio_in (gpio_in),
        .cfg     (cfg.sync)
    );

    gpio_irq_ctrl #(
        .NUM_PADS (NUM_PADS)
    ) u_irq (
        .HCLK      (HCLK),
        .HRESETn   (HRESETn),
        .cfg       (cfg.irq),
        .interrupt (interrupt)
    );

    // Zero wait states, no error responses
    assign PREADY  = 1'b1;
    assign PSLVERR = 1'b0;

endmodule

//--- tb/gpio_clk_gen.sv
`timescale 1ns/1ps
// Testbench clock and reset source
// Free running clock, reset held low for the first few cycles
module gpio_clk_gen #(
    parameter int PERIOD_NS  = 8,
    parameter int RST_CYCLES = 8
) (
    output logic HCLK,
    output logic HRESETn
);

    initial
    begin
        HCLK = 1'b0;
        forever #(PERIOD_NS/2) HCLK = ~HCLK;
    end

    initial
    begin
        HRESETn = 1'b0;
        repeat (RST_CYCLES) @(posedge HCLK);
        #1 HRESETn = 1'b1;  // release clear of the edge
    end

endmodule

//--- tb/gpio_tb.sv
`timescale 1ns/1ps
// APB GPIO testbench
// Directed register, synchroniser and interrupt tests against a small model
module gpio_tb import gpio_pkg::*; ();

    localparam int NUM_PADS        = 32;
    localparam int CLK_NS          = 8;
    localparam int DRIVE_DLY       = 1;
    localparam int NUM_TESTS       = 5;
    localparam int CYCLES_PER_TEST = 3000;
    localparam logic [31:0] EXP_DIR_RESET = 32'h0000_03FF;  // pads 0-9 outputs

    logic                HCLK;
    logic                HRESETn;
    logic [11:0]         PADDR;
    logic [31:0]         PWDATA;
    logic                PWRITE;
    logic                PSEL;
    logic                PENABLE;
    logic [31:0]         PRDATA;
    logic                PREADY;
    logic                PSLVERR;
    logic [NUM_PADS-1:0] gpio_in;
    logic [NUM_PADS-1:0] gpio_out;
    logic [NUM_PADS-1:0] gpio_dir;
    logic                interrupt;

    // Model of registers, settled input state and sticky status
    logic [31:0] exp_dir;
    logic [31:0] exp_en;
    logic [31:0] exp_out;
    logic [31:0] exp_inten;
    logic [31:0] exp_sync;
    logic [31:0] exp_status;
    logic [1:0]  exp_type [NUM_PADS];
    int          seed = 89;

    gpio_clk_gen #(.PERIOD_NS(CLK_NS), .RST_CYCLES(8)) u_clk_gen (
        .HCLK    (HCLK),
        .HRESETn (HRESETn)
    );

    gpio_top #(.NUM_PADS(NUM_PADS), .APB_ADDR_W(12)) u_dut (
        .HCLK      (HCLK),
        .HRESETn   (HRESETn),
        .PADDR     (PADDR),
        .PWDATA    (PWDATA),
        .PWRITE    (PWRITE),
        .PSEL      (PSEL),
        .PENABLE   (PENABLE),
        .PRDATA    (PRDATA),
        .PREADY    (PREADY),
        .PSLVERR   (PSLVERR),
        .gpio_in   (gpio_in),
        .gpio_out  (gpio_out),
        .gpio_dir  (gpio_dir),
        .interrupt (interrupt)
    );

    initial
    begin
        #(NUM_TESTS * CYCLES_PER_TEST * CLK_NS);
        $display("Test FAILED");
        $fatal(1, "Timeout: tests did not finish within %0d clock cycles",
               NUM_TESTS * CYCLES_PER_TEST);
    end

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp)
        begin
            $display("ERROR at %0t ns: %s = 0x%08h, expected 0x%08h", $time, name, got, exp);
            $display("Test FAILED");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    task automatic apb_write(input logic [4:0] idx, input logic [31:0] data);
        @(posedge HCLK);
        #DRIVE_DLY;
        PADDR   = {5'b0, idx, 2'b00};
        PWDATA  = data;
        PWRITE  = 1'b1;
        PSEL    = 1'b1;
        PENABLE = 1'b0;
        @(posedge HCLK);
        #DRIVE_DLY;
        PENABLE = 1'b1;
        #2;
        check("PREADY", 32'(PREADY), 32'h1);  // zero wait states
        check("PSLVERR", 32'(PSLVERR), 32'h0);
        @(posedge HCLK);  // write lands here
        #DRIVE_DLY;
        PSEL    = 1'b0;
        PENABLE = 1'b0;
        PWRITE  = 1'b0;
    endtask

    task automatic apb_read(input logic [4:0] idx, output logic [31:0] data);
        @(posedge HCLK);
        #DRIVE_DLY;
        PADDR   = {5'b0, idx, 2'b00};
        PWRITE  = 1'b0;
        PSEL    = 1'b1;
        PENABLE = 1'b0;
        #2;
        check("PRDATA in setup phase", PRDATA, 32'h0);
        @(posedge HCLK);
        #DRIVE_DLY;
        PENABLE = 1'b1;
        #2;
        data = PRDATA;  // mid access phase
        check("PREADY", 32'(PREADY), 32'h1);
        check("PSLVERR", 32'(PSLVERR), 32'h0);
        @(posedge HCLK);
        #DRIVE_DLY;
        PSEL    = 1'b0;
        PENABLE = 1'b0;
    endtask

    function automatic string reg_name(input logic [4:0] idx);
        gpio_reg_e r;
        r = gpio_reg_e'(idx);
        if (idx > REG_INTSTATUS)
            return $sformatf("unmapped word %0d", idx);
        return r.name();
    endfunction

    function automatic logic [31:0] grp_mask(input logic [31:0] en);
        logic [31:0] m;
        m = '0;
        for (int g = 0; g < NUM_PADS/4; g++)
            if (|en[4*g +: 4])
                m[4*g +: 4] = 4'hF;
        return m;
    endfunction

    function automatic logic type_match(input logic [1:0] t, input logic new_val);
        case (t)
            INT_FALL: return !new_val;
            INT_RISE: return new_val;
            INT_BOTH: return 1'b1;
            default:  return 1'b0;
        endcase
    endfunction

    function automatic logic [31:0] model_word(input logic [4:0] idx);
        logic [31:0] w;
        w = '0;
        case (idx)
            REG_PADDIR:     w = exp_dir;
            REG_GPIOEN:     w = exp_en;
            REG_PADIN:      w = exp_sync;
            REG_PADOUT:     w = exp_out;
            REG_INTEN:      w = exp_inten;
            REG_INTTYPE_LO: for (int f = 0; f < 16; f++) w[2*f +: 2] = exp_type[f];
            REG_INTTYPE_HI: for (int f = 0; f < 16; f++) w[2*f +: 2] = exp_type[16+f];
            REG_INTSTATUS:  w = exp_status;
            default:        w = '0;
        endcase
        return w;
    endfunction

    task automatic reg_write(input logic [4:0] idx, input logic [31:0] data);
        apb_write(idx, data);
        case (idx)
            REG_PADDIR:     exp_dir = data;
            REG_GPIOEN:     exp_en = data;
            REG_PADOUT:     exp_out = data;
            REG_PADOUTSET:  exp_out |= data;
            REG_PADOUTCLR:  exp_out &= ~data;
            REG_INTEN:      exp_inten = data;
            REG_INTTYPE_LO: for (int f = 0; f < 16; f++) exp_type[f] = data[2*f +: 2];
            REG_INTTYPE_HI: for (int f = 0; f < 16; f++) exp_type[16+f] = data[2*f +: 2];
            default:        ;
        endcase
    endtask

    // INTTYPE words compared field by field
    task automatic read_check(input logic [4:0] idx);
        logic [31:0] rd;
        logic [31:0] exp;
        apb_read(idx, rd);
        exp = model_word(idx);
        if (idx == REG_INTTYPE_LO || idx == REG_INTTYPE_HI)
        begin
            for (int f = 0; f < 16; f++)
                check($sformatf("%s field %0d", reg_name(idx), f),
                      32'(rd[2*f +: 2]), 32'(exp[2*f +: 2]));
        end
        else
            check(reg_name(idx), rd, exp);
    endtask

    // Pads in running groups whose input moved since the last settle
    task automatic settle_model(output logic [31:0] evt);
        logic [31:0] run;
        run = grp_mask(exp_en);
        evt = '0;
        for (int i = 0; i < NUM_PADS; i++)
        begin
            if (run[i] && gpio_in[i] !== exp_sync[i])
            begin
                if (exp_en[i] && exp_inten[i] && type_match(exp_type[i], gpio_in[i]))
                    evt[i] = 1'b1;
                exp_sync[i] = gpio_in[i];
            end
        end
        exp_status |= evt;
    endtask

    task automatic wait_settle();
        logic [31:0] evt;
        repeat (4) @(posedge HCLK);
        settle_model(evt);
    endtask

    task automatic drive_pads(input logic [31:0] val);
        @(posedge HCLK);
        #DRIVE_DLY;
        gpio_in = val;
        wait_settle();
    endtask

    task automatic toggle_and_check(input int pad, input logic val);
        logic [31:0] evt;
        logic [31:0] rd;
        logic        hit;
        hit = exp_en[pad] & exp_inten[pad] & type_match(exp_type[pad], val);
        @(posedge HCLK);
        #DRIVE_DLY;
        gpio_in[pad] = val;
        @(posedge HCLK);
        @(negedge HCLK);
        check("interrupt after edge 1", 32'(interrupt), 32'h0);
        @(negedge HCLK);
        check("interrupt after edge 2", 32'(interrupt), 32'(hit));
        @(negedge HCLK);
        check("interrupt after edge 3", 32'(interrupt), 32'h0);
        settle_model(evt);
        apb_read(REG_INTSTATUS, rd);
        check("INTSTATUS", rd, 32'(hit) << pad);
        exp_status = '0;  // cleared by that read
        apb_read(REG_INTSTATUS, rd);
        check("INTSTATUS second read", rd, 32'h0);
    endtask

    task automatic test_reset();
        check("gpio_dir", gpio_dir, EXP_DIR_RESET);
        check("gpio_out", gpio_out, 32'h0);
        check("interrupt", 32'(interrupt), 32'h0);
        for (int i = 0; i < 32; i++)
            read_check(5'(i));
    endtask

    task automatic test_registers();
        logic [31:0] pats [4];
        pats = '{32'hFFFF_FFFF, 32'hA5A5_5A5A, 32'h1234_5678, 32'h0000_0000};
        foreach (pats[p])
        begin
            reg_write(REG_PADDIR, pats[p]);
            reg_write(REG_GPIOEN, pats[p]);
            reg_write(REG_PADOUT, ~pats[p]);
            reg_write(REG_INTEN, pats[p]);
            reg_write(REG_INTTYPE_LO, pats[p]);
            reg_write(REG_INTTYPE_HI, ~pats[p]);
            for (int i = 0; i <= REG_INTSTATUS; i++)
                read_check(5'(i));
            check("gpio_dir", gpio_dir, exp_dir);
            check("gpio_out", gpio_out, exp_out);
        end
        reg_write(REG_PADOUT, 32'h0F0F_00FF);
        reg_write(REG_PADOUTSET, 32'h3000_0100);
        read_check(REG_PADOUT);
        check("gpio_out", gpio_out, exp_out);
        reg_write(REG_PADOUTCLR, 32'h0F00_00F0);
        read_check(REG_PADOUT);
        check("gpio_out", gpio_out, exp_out);
        apb_write(REG_PADIN, 32'hFFFF_FFFF);      // read only
        apb_write(REG_INTSTATUS, 32'hFFFF_FFFF);
        for (int i = REG_INTSTATUS + 1; i < 32; i++)
        begin
            apb_write(5'(i), 32'hFFFF_FFFF);
            read_check(5'(i));
        end
        for (int i = 0; i <= REG_INTSTATUS; i++)
            read_check(5'(i));
        reg_write(REG_GPIOEN, 32'h0);
        reg_write(REG_INTEN, 32'h0);
        reg_write(REG_INTTYPE_LO, 32'h0);
        reg_write(REG_INTTYPE_HI, 32'h0);
    endtask

    task automatic test_sync();
        reg_write(REG_GPIOEN, 32'h0000_0F0F);  // groups 0 and 2
        drive_pads(32'hDEAD_BEEF);
        read_check(REG_PADIN);
        reg_write(REG_GPIOEN, 32'h1010_1000);  // groups 3, 5 and 7
        drive_pads(32'h1357_9BDF);
        read_check(REG_PADIN);
        reg_write(REG_GPIOEN, 32'hFFFF_FFFF);
        drive_pads(32'h0);
        read_check(REG_PADIN);
    endtask

    task automatic test_irq_types();
        reg_write(REG_INTEN, 32'h0000_000F);
        reg_write(REG_INTTYPE_LO, {24'h0, INT_NONE, INT_BOTH, INT_RISE, INT_FALL});
        reg_write(REG_GPIOEN, 32'h0000_000F);
        wait_settle();
        for (int p = 0; p < 4; p++)
        begin
            toggle_and_check(p, 1'b1);
            toggle_and_check(p, 1'b0);
        end
    endtask

    task automatic test_random();
        logic [31:0] rd;
        for (int b = 0; b < 20; b++)
        begin
            reg_write(REG_INTEN, $random(seed));
            reg_write(REG_INTTYPE_LO, $random(seed));
            reg_write(REG_INTTYPE_HI, $random(seed));
            reg_write(REG_GPIOEN, $random(seed));  // last, so stale edges see new config
            wait_settle();
            for (int t = 0; t < 8; t++)
                drive_pads(gpio_in ^ $random(seed));
            apb_read(REG_INTSTATUS, rd);
            check("INTSTATUS masked pads", rd & ~(exp_en & exp_inten), 32'h0);
            check("INTSTATUS batch", rd, exp_status);
            exp_status = '0;
        end
    endtask

    initial
    begin
        PADDR      = '0;
        PWDATA     = '0;
        PWRITE     = 1'b0;
        PSEL       = 1'b0;
        PENABLE    = 1'b0;
        gpio_in    = '0;
        exp_dir    = EXP_DIR_RESET;
        exp_en     = '0;
        exp_out    = '0;
        exp_inten  = '0;
        exp_sync   = '0;
        exp_status = '0;
        for (int i = 0; i < NUM_PADS; i++)
            exp_type[i] = INT_FALL;
        wait (HRESETn === 1'b1);
        test_reset();
        test_registers();
        test_sync();
        test_irq_types();
        test_random();
        $display("Test OK");
        $finish;
    end

endmodule

//--- compile.f
hw/gpio_pkg.sv
hw/gpio_cfg_if.sv
hw/gpio_apb_regs.sv
hw/gpio_in_sync.sv
hw/gpio_irq_ctrl.sv
hw/gpio_top.sv
tb/gpio_clk_gen.sv
tb/gpio_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing
TOP       := gpio_tb
FILELIST  := compile.f
OBJ_DIR   := obj_dir

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(BIN)
	@out=$$(./$(BIN)); echo "$$out"; echo "$$out" | grep -qx "Test OK"

clean:
	rm -rf $(OBJ_DIR)
